/* files.f */
+incdir+hdl
hdl/procyon_types_pkg.sv
hdl/procyon_ops_pkg.sv
hdl/sync_fifo.sv
hdl/ieu.sv
hdl/mul_unit.sv
hdl/cdb_arbiter.sv
hdl/reorder_buffer.sv
hdl/procyon_exec.sv
verif/clock_gen.sv
verif/procyon_exec_tb.sv

/* run.sh */
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps -f files.f --top-module procyon_exec_tb

output=$(./obj_dir/Vprocyon_exec_tb 2>&1) || true
echo "$output"

if echo "$output" | grep -q "ALL TESTS PASSED"; then
    exit 0
else
    echo "run.sh: pass message not found in simulation output"
    exit 1
fi

/* verif/procyon_exec_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module procyon_exec_tb;

    import procyon_types_pkg::*;
    import procyon_ops_pkg::*;

    localparam int NUM_ROWS       = 24;
    localparam int RESET_CYCLES   = 4;
    localparam int DRIVE_DELAY    = 1;
    localparam int TIMEOUT_CYCLES = NUM_ROWS * 12 + 50;

    // A set burst bit means the next row follows with no idle cycle
    typedef struct {
        procyon_op_t   op;
        procyon_reg_t  rdest;
        procyon_data_t src_a;
        procyon_data_t src_b;
        logic          burst;
    } stim_row_t;

    logic          clk;
    logic          i_reset;
    logic          i_dispatch_en;
    procyon_op_t   i_dispatch_op;
    procyon_reg_t  i_dispatch_rdest;
    procyon_data_t i_dispatch_src_a;
    procyon_data_t i_dispatch_src_b;
    logic          o_rob_full;
    logic          o_retire_en;
    procyon_reg_t  o_retire_rdest;
    procyon_data_t o_retire_data;

    stim_row_t     rows [NUM_ROWS];
    procyon_data_t expected_data[$];
    procyon_reg_t  expected_rdest[$];
    procyon_data_t exp_data;
    procyon_reg_t  exp_rdest;
    logic [31:0]   rng_state;
    int            idle_cycles;
    int            retired_count;
    int            cycle_count;

    clock_gen #(.PERIOD_NS(20)) clk_gen (.o_clk(clk));

    procyon_exec uut (
        .clk(clk),
        .i_reset(i_reset),
        .i_dispatch_en(i_dispatch_en),
        .i_dispatch_op(i_dispatch_op),
        .i_dispatch_rdest(i_dispatch_rdest),
        .i_dispatch_src_a(i_dispatch_src_a),
        .i_dispatch_src_b(i_dispatch_src_b),
        .o_rob_full(o_rob_full),
        .o_retire_en(o_retire_en),
        .o_retire_rdest(o_retire_rdest),
        .o_retire_data(o_retire_data)
    );

    function automatic logic [31:0] next_random(input logic [31:0] state);
        logic [31:0] x;
        x = state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic procyon_data_t reference_result(input procyon_op_t op,
                                                       input procyon_data_t a,
                                                       input procyon_data_t b);
        logic [63:0]   product;
        logic [4:0]    shamt;
        procyon_data_t result;
        product = 64'(a) * 64'(b);
        shamt   = b[4:0];
        case (op)
            OP_ADD:  result = a + b;
            OP_SUB:  result = a + ~b + 32'd1;
            OP_AND:  result = a & b;
            OP_OR:   result = a | b;
            OP_XOR:  result = a ^ b;
            OP_SLL:  result = a << shamt;
            OP_SRL:  result = a >> shamt;
            // Differing signs decide at once and equal signs compare as unsigned
            OP_SLT:  result = (a[31] != b[31]) ? {31'd0, a[31]} : {31'd0, a < b};
            OP_MUL:  result = product[31:0];
            default: result = '0;
        endcase
        return result;
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("** Error at time %0t: %s = 0x%08h, expected 0x%08h",
                     $time, name, actual, expected);
            $display("SOME TESTS FAILED");
            $fatal(1);
        end
    endtask

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("SOME TESTS FAILED");
        $fatal(1);
    endtask

    task load_table();
        // Integer unit, one row per operation
        rows[0]  = '{OP_ADD, 5'd1,  32'h0000_0005, 32'h0000_0007, 1'b0};
        rows[1]  = '{OP_SUB, 5'd2,  32'h0000_0003, 32'h0000_000a, 1'b0};
        rows[2]  = '{OP_AND, 5'd3,  32'hf0f0_f0f0, 32'hff00_ff00, 1'b0};
        rows[3]  = '{OP_OR,  5'd4,  32'h1234_0000, 32'h0000_5678, 1'b0};
        rows[4]  = '{OP_XOR, 5'd5,  32'haaaa_5555, 32'hffff_0000, 1'b0};
        rows[5]  = '{OP_SLL, 5'd6,  32'h0000_0001, 32'h0000_0023, 1'b0};
        rows[6]  = '{OP_SRL, 5'd7,  32'h8000_0000, 32'h0000_003f, 1'b0};
        rows[7]  = '{OP_SLT, 5'd8,  32'hffff_fff6, 32'h0000_0003, 1'b0};
        rows[8]  = '{OP_SLT, 5'd9,  32'h0000_0005, 32'hffff_ffff, 1'b0};
        rows[9]  = '{OP_SLT, 5'd10, 32'h8000_0000, 32'h7fff_ffff, 1'b0};
        // Multiplier with high bits set
        rows[10] = '{OP_MUL, 5'd11, 32'h1234_5678, 32'h9abc_def0, 1'b0};
        rows[11] = '{OP_MUL, 5'd12, 32'hffff_ffff, 32'hffff_ffff, 1'b0};
        // MUL then ADDs that reach the bus first
        rows[12] = '{OP_MUL, 5'd13, 32'h0001_0003, 32'h0002_0005, 1'b1};
        rows[13] = '{OP_ADD, 5'd14, 32'h0000_0100, 32'h0000_0001, 1'b1};
        rows[14] = '{OP_ADD, 5'd15, 32'hffff_ffff, 32'h0000_0001, 1'b1};
        rows[15] = '{OP_ADD, 5'd16, 32'h7fff_ffff, 32'h0000_0001, 1'b0};
        // Back-to-back run mixing both units
        rows[16] = '{OP_MUL, 5'd17, 32'h0000_ffff, 32'h0001_0001, 1'b1};
        rows[17] = '{OP_XOR, 5'd18, 32'h0f0f_0f0f, 32'h00ff_00ff, 1'b1};
        rows[18] = '{OP_MUL, 5'd19, 32'hdead_beef, 32'h0000_0010, 1'b1};
        rows[19] = '{OP_SUB, 5'd20, 32'h0000_0000, 32'h0000_0001, 1'b1};
        rows[20] = '{OP_MUL, 5'd21, 32'h8000_0001, 32'h8000_0001, 1'b1};
        rows[21] = '{OP_SLL, 5'd22, 32'h0000_00ff, 32'h0000_0028, 1'b1};
        rows[22] = '{OP_MUL, 5'd23, 32'hcafe_f00d, 32'h1357_9bdf, 1'b1};
        rows[23] = '{OP_ADD, 5'd0,  32'h0000_0011, 32'h0000_0022, 1'b0};
    endtask

    task dispatch_row(input int idx);
        // Hold off while the reorder buffer is full
        while (o_rob_full) begin
            @(posedge clk);
            #DRIVE_DELAY;
        end
        i_dispatch_en    = 1'b1;
        i_dispatch_op    = rows[idx].op;
        i_dispatch_rdest = rows[idx].rdest;
        i_dispatch_src_a = rows[idx].src_a;
        i_dispatch_src_b = rows[idx].src_b;
        expected_data.push_back(reference_result(rows[idx].op, rows[idx].src_a,
                                                 rows[idx].src_b));
        expected_rdest.push_back(rows[idx].rdest);
        @(posedge clk);
        #DRIVE_DELAY;
        i_dispatch_en = 1'b0;
    endtask

    // Retirement monitor samples away from the rising edge
    always @(negedge clk) begin
        if (!i_reset && o_retire_en) begin
            if (expected_data.size() == 0) begin
                stop_with_failure("Retirement seen with no instruction outstanding");
            end else begin
                exp_data  = expected_data.pop_front();
                exp_rdest = expected_rdest.pop_front();
                check_value("o_retire_data", o_retire_data, exp_data);
                check_value("o_retire_rdest", 32'(o_retire_rdest), 32'(exp_rdest));
                retired_count++;
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            stop_with_failure("Timeout: not every instruction retired in time");
        end
    end

    initial begin
        i_reset          = 1'b1;
        i_dispatch_en    = 1'b0;
        i_dispatch_op    = OP_ADD;
        i_dispatch_rdest = '0;
        i_dispatch_src_a = '0;
        i_dispatch_src_b = '0;
        rng_state        = 32'hbf2d;
        retired_count    = 0;
        cycle_count      = 0;
        load_table();

        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        i_reset = 1'b0;

        // Quiet cycles before the first dispatch
        repeat (3) @(posedge clk);
        #DRIVE_DELAY;
        check_value("o_retire_en", 32'(o_retire_en), 32'd0);
        check_value("o_rob_full", 32'(o_rob_full), 32'd0);

        for (int i = 0; i < NUM_ROWS; i++) begin
            dispatch_row(i);
            if (!rows[i].burst) begin
                rng_state   = next_random(rng_state);
                idle_cycles = int'(rng_state[1:0]);
                repeat (idle_cycles) begin
                    @(posedge clk);
                    #DRIVE_DELAY;
                end
            end
        end

        while (retired_count < NUM_ROWS) begin
            @(posedge clk);
        end
        // Leave room for a stray extra retirement to show up
        repeat (5) @(posedge clk);

        if (retired_count == NUM_ROWS && expected_data.size() == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verif/clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module clock_gen #(
    parameter int PERIOD_NS = 20
) (
    output logic o_clk
);

    initial begin
        o_clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2) o_clk = ~o_clk;
        end
    end

endmodule

`default_nettype wire

/* hdl/procyon_exec.sv */
`timescale 1ns/1ps
`default_nettype none

module procyon_exec (
    input  logic                             clk,
    input  logic                             i_reset,
    input  logic                             i_dispatch_en,
    input  procyon_ops_pkg::procyon_op_t     i_dispatch_op,
    input  procyon_types_pkg::procyon_reg_t  i_dispatch_rdest,
    input  procyon_types_pkg::procyon_data_t i_dispatch_src_a,
    input  procyon_types_pkg::procyon_data_t i_dispatch_src_b,
    output logic                             o_rob_full,
    output logic                             o_retire_en,
    output procyon_types_pkg::procyon_reg_t  o_retire_rdest,
    output procyon_types_pkg::procyon_data_t o_retire_data
);

    import procyon_types_pkg::*;
    import procyon_ops_pkg::*;

    procyon_tag_t   alloc_tag;
    procyon_fu_t    fu_sel;
    logic           ieu_en;
    logic           mul_en;

    logic           ieu_req;
    procyon_tag_t   ieu_tag;
    procyon_data_t  ieu_data;
    logic           ieu_grant;
    logic           mul_req;
    procyon_tag_t   mul_tag;
    procyon_data_t  mul_data;
    logic           mul_grant;

    logic           cdb_en;
    procyon_tag_t   cdb_tag;
    procyon_data_t  cdb_data;

    // Only MUL goes to the multiplier
    assign fu_sel = (i_dispatch_op == OP_MUL) ? FU_MUL : FU_IEU;
    assign ieu_en = i_dispatch_en && (fu_sel == FU_IEU);
    assign mul_en = i_dispatch_en && (fu_sel == FU_MUL);

    reorder_buffer rob_inst (
        .clk(clk),
        .i_reset(i_reset),
        .i_dispatch_en(i_dispatch_en),
        .i_dispatch_rdest(i_dispatch_rdest),
        .o_alloc_tag(alloc_tag),
        .o_full(o_rob_full),
        .i_cdb_en(cdb_en),
        .i_cdb_tag(cdb_tag),
        .i_cdb_data(cdb_data),
        .o_retire_en(o_retire_en),
        .o_retire_rdest(o_retire_rdest),
        .o_retire_data(o_retire_data)
    );

    ieu ieu_inst (
        .clk(clk),
        .i_reset(i_reset),
        .i_en(ieu_en),
        .i_op(i_dispatch_op),
        .i_tag(alloc_tag),
        .i_src_a(i_dispatch_src_a),
        .i_src_b(i_dispatch_src_b),
        .i_grant(ieu_grant),
        .o_req(ieu_req),
        .o_tag(ieu_tag),
        .o_data(ieu_data)
    );

    mul_unit mul_inst (
        .clk(clk),
        .i_reset(i_reset),
        .i_en(mul_en),
        .i_tag(alloc_tag),
        .i_src_a(i_dispatch_src_a),
        .i_src_b(i_dispatch_src_b),
        .i_grant(mul_grant),
        .o_req(mul_req),
        .o_tag(mul_tag),
        .o_data(mul_data)
    );

    cdb_arbiter cdb_arbiter_inst (
        .clk(clk),
        .i_reset(i_reset),
        .i_ieu_req(ieu_req),
        .i_ieu_tag(ieu_tag),
        .i_ieu_data(ieu_data),
        .i_mul_req(mul_req),
        .i_mul_tag(mul_tag),
        .i_mul_data(mul_data),
        .o_ieu_grant(ieu_grant),
        .o_mul_grant(mul_grant),
        .o_cdb_en(cdb_en),
        .o_cdb_tag(cdb_tag),
        .o_cdb_data(cdb_data)
    );

endmodule

`default_nettype wire

/* hdl/reorder_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "procyon_cfg.svh"

module reorder_buffer (
    input  logic                             clk,
    input  logic                             i_reset,
    input  logic                             i_dispatch_en,
    input  procyon_types_pkg::procyon_reg_t  i_dispatch_rdest,
    output procyon_types_pkg::procyon_tag_t  o_alloc_tag,
    output logic                             o_full,
    input  logic                             i_cdb_en,
    input  procyon_types_pkg::procyon_tag_t  i_cdb_tag,
    input  procyon_types_pkg::procyon_data_t i_cdb_data,
    output logic                             o_retire_en,
    output procyon_types_pkg::procyon_reg_t  o_retire_rdest,
    output procyon_types_pkg::procyon_data_t o_retire_data
);

    import procyon_types_pkg::*;
    import procyon_ops_pkg::*;

    rob_state_t           entry_state [0:`ROB_DEPTH-1];
    procyon_reg_t         entry_rdest [0:`ROB_DEPTH-1];
    procyon_data_t        entry_data  [0:`ROB_DEPTH-1];

    procyon_tag_t         head;
    procyon_tag_t         tail;
    logic [`TAG_WIDTH:0]  count;
    logic                 alloc;
    logic                 retire;

    assign o_alloc_tag = tail;
    assign o_full      = (count == (`TAG_WIDTH+1)'(`ROB_DEPTH));
    assign alloc       = i_dispatch_en && !o_full;
    assign retire      = (entry_state[head] == ROB_DONE);

    // Tail and head wrap on their own since the tag width matches the depth
    always_ff @(posedge clk) begin
        if (i_reset) begin
            for (int i = 0; i < `ROB_DEPTH; i++) begin
                entry_state[i] <= ROB_EMPTY;
            end
            head        <= '0;
            tail        <= '0;
            count       <= '0;
            o_retire_en <= 1'b0;
        end else begin
            o_retire_en <= retire;
            if (alloc) begin
                entry_state[tail] <= ROB_BUSY;
                tail              <= tail + 1'b1;
            end
            if (i_cdb_en) begin
                entry_state[i_cdb_tag] <= ROB_DONE;
            end
            if (retire) begin
                entry_state[head] <= ROB_EMPTY;
                head              <= head + 1'b1;
            end
            case ({alloc, retire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (alloc) begin
            entry_rdest[tail] <= i_dispatch_rdest;
        end
        if (i_cdb_en) begin
            entry_data[i_cdb_tag] <= i_cdb_data;
        end
        if (retire) begin
            o_retire_rdest <= entry_rdest[head];
            o_retire_data  <= entry_data[head];
        end
    end

endmodule

`default_nettype wire

/* hdl/cdb_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module cdb_arbiter (
    input  logic                             clk,
    input  logic                             i_reset,
    input  logic                             i_ieu_req,
    input  procyon_types_pkg::procyon_tag_t  i_ieu_tag,
    input  procyon_types_pkg::procyon_data_t i_ieu_data,
    input  logic                             i_mul_req,
    input  procyon_types_pkg::procyon_tag_t  i_mul_tag,
    input  procyon_types_pkg::procyon_data_t i_mul_data,
    output logic                             o_ieu_grant,
    output logic                             o_mul_grant,
    output logic                             o_cdb_en,
    output procyon_types_pkg::procyon_tag_t  o_cdb_tag,
    output procyon_types_pkg::procyon_data_t o_cdb_data
);

    import procyon_ops_pkg::*;

    procyon_fu_t last_winner;

    // On a tie the unit that did not win last time goes first
    assign o_ieu_grant = i_ieu_req && (!i_mul_req || (last_winner == FU_MUL));
    assign o_mul_grant = i_mul_req && !o_ieu_grant;

    always_ff @(posedge clk) begin
        if (i_reset) begin
            o_cdb_en    <= 1'b0;
            last_winner <= FU_MUL;
        end else begin
            o_cdb_en <= o_ieu_grant || o_mul_grant;
            if (o_ieu_grant) begin
                last_winner <= FU_IEU;
            end else if (o_mul_grant) begin
                last_winner <= FU_MUL;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (o_ieu_grant) begin
            o_cdb_tag  <= i_ieu_tag;
            o_cdb_data <= i_ieu_data;
        end else if (o_mul_grant) begin
            o_cdb_tag  <= i_mul_tag;
            o_cdb_data <= i_mul_data;
        end
    end

endmodule

`default_nettype wire

/* hdl/mul_unit.sv */
`timescale 1ns/1ps
`default_nettype none

`include "procyon_cfg.svh"

module mul_unit (
    input  logic                             clk,
    input  logic                             i_reset,
    input  logic                             i_en,
    input  procyon_types_pkg::procyon_tag_t  i_tag,
    input  procyon_types_pkg::procyon_data_t i_src_a,
    input  procyon_types_pkg::procyon_data_t i_src_b,
    input  logic                             i_grant,
    output logic                             o_req,
    output procyon_types_pkg::procyon_tag_t  o_tag,
    output procyon_types_pkg::procyon_data_t o_data
);

    import procyon_types_pkg::*;

    localparam int HALF        = `DATA_WIDTH / 2;
    localparam int QUEUE_WIDTH = `TAG_WIDTH + `DATA_WIDTH;

    logic                   s1_valid;
    procyon_tag_t           s1_tag;
    logic [HALF-1:0]        s1_a_hi;
    logic [HALF-1:0]        s1_a_lo;
    logic [HALF-1:0]        s1_b_hi;
    logic [HALF-1:0]        s1_b_lo;

    logic                   s2_valid;
    procyon_tag_t           s2_tag;
    procyon_data_t          s2_pp_ll;
    procyon_data_t          s2_pp_hl;
    procyon_data_t          s2_pp_lh;

    procyon_data_t          s3_product;
    logic [QUEUE_WIDTH-1:0] queue_rd_data;
    logic                   queue_empty;

    always_ff @(posedge clk) begin
        if (i_reset) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else begin
            s1_valid <= i_en;
            s2_valid <= s1_valid;
        end
    end

    // The high-by-high product lies entirely above the low word
    always_ff @(posedge clk) begin
        {s1_a_hi, s1_a_lo} <= i_src_a;
        {s1_b_hi, s1_b_lo} <= i_src_b;
        s1_tag             <= i_tag;
        s2_pp_ll           <= s1_a_lo * s1_b_lo;
        s2_pp_hl           <= s1_a_hi * s1_b_lo;
        s2_pp_lh           <= s1_a_lo * s1_b_hi;
        s2_tag             <= s1_tag;
    end

    assign s3_product = s2_pp_ll + ((s2_pp_hl + s2_pp_lh) << HALF);

    sync_fifo #(
        .WIDTH(QUEUE_WIDTH),
        .DEPTH(`ROB_DEPTH)
    ) result_queue (
        .clk(clk),
        .i_reset(i_reset),
        .i_wr_en(s2_valid),
        .i_wr_data({s2_tag, s3_product}),
        .i_rd_en(i_grant),
        .o_rd_data(queue_rd_data),
        .o_empty(queue_empty),
        .o_full()
    );

    assign o_req           = !queue_empty;
    assign {o_tag, o_data} = queue_rd_data;

endmodule

`default_nettype wire

/* hdl/ieu.sv */
`timescale 1ns/1ps
`default_nettype none

`include "procyon_cfg.svh"

module ieu (
    input  logic                             clk,
    input  logic                             i_reset,
    input  logic                             i_en,
    input  procyon_ops_pkg::procyon_op_t     i_op,
    input  procyon_types_pkg::procyon_tag_t  i_tag,
    input  procyon_types_pkg::procyon_data_t i_src_a,
    input  procyon_types_pkg::procyon_data_t i_src_b,
    input  logic                             i_grant,
    output logic                             o_req,
    output procyon_types_pkg::procyon_tag_t  o_tag,
    output procyon_types_pkg::procyon_data_t o_data
);

    import procyon_types_pkg::*;
    import procyon_ops_pkg::*;

    localparam int QUEUE_WIDTH = `TAG_WIDTH + `DATA_WIDTH;

    procyon_data_t          result;
    logic [QUEUE_WIDTH-1:0] queue_rd_data;
    logic                   queue_empty;

    // Shift amounts use only the low 5 bits of operand b
    always_comb begin
        case (i_op)
            OP_ADD:  result = i_src_a + i_src_b;
            OP_SUB:  result = i_src_a - i_src_b;
            OP_AND:  result = i_src_a & i_src_b;
            OP_OR:   result = i_src_a | i_src_b;
            OP_XOR:  result = i_src_a ^ i_src_b;
            OP_SLL:  result = i_src_a << i_src_b[4:0];
            OP_SRL:  result = i_src_a >> i_src_b[4:0];
            OP_SLT:  result = ($signed(i_src_a) < $signed(i_src_b)) ? procyon_data_t'(1) : '0;
            default: result = '0;
        endcase
    end

    sync_fifo #(
        .WIDTH(QUEUE_WIDTH),
        .DEPTH(`ROB_DEPTH)
    ) result_queue (
        .clk(clk),
        .i_reset(i_reset),
        .i_wr_en(i_en),
        .i_wr_data({i_tag, result}),
        .i_rd_en(i_grant),
        .o_rd_data(queue_rd_data),
        .o_empty(queue_empty),
        .o_full()
    );

    assign o_req           = !queue_empty;
    assign {o_tag, o_data} = queue_rd_data;

endmodule

`default_nettype wire

/* hdl/sync_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module sync_fifo #(
    parameter int WIDTH = 8,
    parameter int DEPTH = 8
) (
    input  logic             clk,
    input  logic             i_reset,
    input  logic             i_wr_en,
    input  logic [WIDTH-1:0] i_wr_data,
    input  logic             i_rd_en,
    output logic [WIDTH-1:0] o_rd_data,
    output logic             o_empty,
    output logic             o_full
);

    localparam int PTR_WIDTH = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_WIDTH = $clog2(DEPTH + 1);

    logic [WIDTH-1:0]     mem [0:DEPTH-1];
    logic [PTR_WIDTH-1:0] rd_ptr;
    logic [PTR_WIDTH-1:0] wr_ptr;
    logic [CNT_WIDTH-1:0] count;
    logic                 do_rd;
    logic                 do_wr;

    assign o_empty   = (count == '0);
    assign o_full    = (count == CNT_WIDTH'(DEPTH));
    assign o_rd_data = mem[rd_ptr];
    assign do_rd     = i_rd_en && !o_empty;
    // A full queue still accepts a write when its head leaves in the same cycle
    assign do_wr     = i_wr_en && (!o_full || do_rd);

    always_ff @(posedge clk) begin
        if (i_reset) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_rd) begin
                rd_ptr <= (rd_ptr == PTR_WIDTH'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (do_wr) begin
                wr_ptr <= (wr_ptr == PTR_WIDTH'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= i_wr_data;
        end
    end

endmodule

`default_nettype wire

/* hdl/procyon_ops_pkg.sv */
`default_nettype none

package procyon_ops_pkg;

    typedef enum logic [3:0] {
        OP_ADD = 4'h0,
        OP_SUB = 4'h1,
        OP_AND = 4'h2,
        OP_OR  = 4'h3,
        OP_XOR = 4'h4,
        OP_SLL = 4'h5,
        OP_SRL = 4'h6,
        OP_SLT = 4'h7,
        OP_MUL = 4'h8
    } procyon_op_t;

    typedef enum logic {
        FU_IEU = 1'b0,
        FU_MUL = 1'b1
    } procyon_fu_t;

    typedef enum logic [1:0] {
        ROB_EMPTY = 2'b00,
        ROB_BUSY  = 2'b01,
        ROB_DONE  = 2'b10
    } rob_state_t;

endpackage

`default_nettype wire

/* hdl/procyon_types_pkg.sv */
`default_nettype none

`include "procyon_cfg.svh"

package procyon_types_pkg;

    // Operand or result word
    typedef logic [`DATA_WIDTH-1:0] procyon_data_t;

    // Reorder buffer index
    typedef logic [`TAG_WIDTH-1:0]  procyon_tag_t;

    // Destination register index
    typedef logic [`REG_WIDTH-1:0]  procyon_reg_t;

endpackage

`default_nettype wire

/* hdl/procyon_cfg.svh */
`ifndef PROCYON_CFG_SVH
`define PROCYON_CFG_SVH

// Operand and result word
`define DATA_WIDTH 32

// Architectural register index
`define REG_WIDTH 5

// Reorder buffer size and depth of each result queue
`define ROB_DEPTH 8

// Must be log2 of ROB_DEPTH
`define TAG_WIDTH 3

`endif
